// ==== include/decompose_config.svh ====
`ifndef DECOMPOSE_CONFIG_SVH
`define DECOMPOSE_CONFIG_SVH

// ---------------------------------------------------------------------
// ML-DSA decompose constants
// ---------------------------------------------------------------------

// Field modulus
`define DCMP_Q          8380417

// gamma2 = (q-1)/32
`define DCMP_GAMMA2     261888

// Polynomials per block and coefficients per polynomial
`define DCMP_K          8
`define DCMP_N          256

// Coefficients packed into one memory word
`define DCMP_LANES      4

// Width of one coefficient
`define DCMP_COEFF_W    24

// Source memory holds 1024 words
`define DCMP_ADDR_W     10

`endif

// ==== rtl/decompose_pkg.sv ====
`include "decompose_config.svh"

package decompose_pkg;

    // -----------------------------------------------------------------
    // Data widths
    // -----------------------------------------------------------------
    typedef logic [`DCMP_COEFF_W-1:0] coeff_t;
    typedef logic signed [19:0] r0_t;
    // Raw high part before the q-1 fix, 0 to 16
    typedef logic [4:0] r1_raw_t;
    typedef logic [3:0] r1_t;
    typedef logic [`DCMP_ADDR_W-1:0] mem_addr_t;
    typedef logic [`DCMP_LANES*`DCMP_COEFF_W-1:0] src_word_t;
    // Each lane is {r1, r0 mod q}
    typedef logic [`DCMP_LANES*(4+`DCMP_COEFF_W)-1:0] result_word_t;

    // -----------------------------------------------------------------
    // Memory operations and FSM states
    // -----------------------------------------------------------------
    typedef enum logic [1:0] {RW_IDLE, RW_READ, RW_WRITE} mem_op_e;

    typedef enum logic {DCMP_RD_IDLE, DCMP_RD_MEM} dcmp_read_state_e;

    typedef enum logic {DCMP_WR_IDLE, DCMP_WR_MEM} dcmp_write_state_e;

endpackage

// ==== rtl/dcmp_result_if.sv ====
`timescale 1ns/1ps
`include "decompose_config.svh"

interface dcmp_result_if;

    // Low parts from the mod 2*gamma2 path
    logic r0_valid;
    decompose_pkg::r0_t r0 [`DCMP_LANES];

    // Raw high parts from the threshold ladder
    logic r1_valid;
    decompose_pkg::r1_raw_t r1 [`DCMP_LANES];

    modport r0_src (
        output r0_valid,
        output r0
    );

    // r0_valid is visible here so the two paths can be cross-checked
    modport r1_src (
        input  r0_valid,
        output r1_valid,
        output r1
    );

    modport sink (
        input r0_valid,
        input r0,
        input r1_valid,
        input r1
    );

endinterface

// ==== rtl/poly_src_mem.sv ====
`timescale 1ns/1ps
`include "decompose_config.svh"

module poly_src_mem (
    input  logic                      clk,
    input  logic                      host_wr_en,
    input  decompose_pkg::mem_addr_t  host_addr,
    input  decompose_pkg::src_word_t  host_wdata,
    input  decompose_pkg::mem_op_e    rd_op,
    input  decompose_pkg::mem_addr_t  rd_addr,
    output decompose_pkg::src_word_t  rd_data
);

    localparam int DEPTH = 1 << `DCMP_ADDR_W;

    decompose_pkg::src_word_t mem [DEPTH];

    // Host load port
    always_ff @(posedge clk) begin
        if (host_wr_en) begin
            mem[host_addr] <= host_wdata;
        end
    end

    // Read data appears one cycle after RW_READ
    always_ff @(posedge clk) begin
        if (rd_op == decompose_pkg::RW_READ) begin
            rd_data <= mem[rd_addr];
        end
    end

    // Host may only load while the engine is idle
    host_rd_collision_a: assert property (
        @(posedge clk) !(host_wr_en && (rd_op == decompose_pkg::RW_READ))
    ) else $error("host write collides with decompose read");

endmodule

// ==== rtl/decompose_ctrl.sv ====
`timescale 1ns/1ps
`include "decompose_config.svh"

module decompose_ctrl (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,
    input  logic                      decompose_enable,
    input  decompose_pkg::mem_addr_t  src_base_addr,
    input  decompose_pkg::mem_addr_t  dest_base_addr,
    input  logic                      r0_ready,
    output decompose_pkg::mem_op_e    rd_op,
    output decompose_pkg::mem_addr_t  rd_addr,
    output decompose_pkg::mem_op_e    wr_op,
    output decompose_pkg::mem_addr_t  wr_addr,
    output logic                      decompose_done
);

    // Offset of the last word of a K*N block
    localparam decompose_pkg::mem_addr_t BLOCK_LAST =
        decompose_pkg::mem_addr_t'(`DCMP_K * `DCMP_N / `DCMP_LANES - 1);

    decompose_pkg::mem_addr_t src_base_reg;
    decompose_pkg::mem_addr_t dest_base_reg;
    logic rd_last;
    logic wr_last;
    logic rd_busy;

    decompose_pkg::dcmp_read_state_e  rd_state, rd_state_nxt;
    decompose_pkg::dcmp_write_state_e wr_state, wr_state_nxt;

    // -----------------------------------------------------------------
    // Address counters
    // -----------------------------------------------------------------
    // Base is captured every idle cycle, so the value at the start strobe sticks
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_addr      <= '0;
            src_base_reg <= '0;
        end else if (zeroize) begin
            rd_addr      <= '0;
            src_base_reg <= '0;
        end else if (rd_state == decompose_pkg::DCMP_RD_IDLE) begin
            rd_addr      <= src_base_addr;
            src_base_reg <= src_base_addr;
        end else begin
            rd_addr <= rd_addr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_addr       <= '0;
            dest_base_reg <= '0;
        end else if (zeroize) begin
            wr_addr       <= '0;
            dest_base_reg <= '0;
        end else if (wr_state == decompose_pkg::DCMP_WR_IDLE) begin
            wr_addr       <= dest_base_addr;
            dest_base_reg <= dest_base_addr;
        end else begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    // End of block, wrapping modulo memory depth
    assign rd_last = (rd_addr == decompose_pkg::mem_addr_t'(src_base_reg + BLOCK_LAST));
    assign wr_last = (wr_addr == decompose_pkg::mem_addr_t'(dest_base_reg + BLOCK_LAST));
    assign rd_busy = (rd_state == decompose_pkg::DCMP_RD_MEM);

    // -----------------------------------------------------------------
    // Read and write FSMs
    // -----------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state <= decompose_pkg::DCMP_RD_IDLE;
            wr_state <= decompose_pkg::DCMP_WR_IDLE;
        end else if (zeroize) begin
            rd_state <= decompose_pkg::DCMP_RD_IDLE;
            wr_state <= decompose_pkg::DCMP_WR_IDLE;
        end else begin
            rd_state <= rd_state_nxt;
            wr_state <= wr_state_nxt;
        end
    end

    always_comb begin
        rd_state_nxt = rd_state;
        case (rd_state)
            decompose_pkg::DCMP_RD_IDLE:
                if (decompose_enable) rd_state_nxt = decompose_pkg::DCMP_RD_MEM;
            decompose_pkg::DCMP_RD_MEM:
                if (rd_last) rd_state_nxt = decompose_pkg::DCMP_RD_IDLE;
            default:
                rd_state_nxt = decompose_pkg::DCMP_RD_IDLE;
        endcase
    end

    // Writes start once the first result leaves the arithmetic stage
    always_comb begin
        wr_state_nxt = wr_state;
        case (wr_state)
            decompose_pkg::DCMP_WR_IDLE:
                if (rd_busy && r0_ready) wr_state_nxt = decompose_pkg::DCMP_WR_MEM;
            decompose_pkg::DCMP_WR_MEM:
                if (wr_last) wr_state_nxt = decompose_pkg::DCMP_WR_IDLE;
            default:
                wr_state_nxt = decompose_pkg::DCMP_WR_IDLE;
        endcase
    end

    assign rd_op = rd_busy ? decompose_pkg::RW_READ : decompose_pkg::RW_IDLE;
    assign wr_op = (wr_state == decompose_pkg::DCMP_WR_MEM) ?
                   decompose_pkg::RW_WRITE : decompose_pkg::RW_IDLE;
    assign decompose_done = (rd_state == decompose_pkg::DCMP_RD_IDLE) &&
                            (wr_state == decompose_pkg::DCMP_WR_IDLE);

    // Write side only starts on a valid result
    wr_start_needs_ready_a: assert property (
        @(posedge clk) disable iff (!reset_n)
        (wr_state == decompose_pkg::DCMP_WR_IDLE && !r0_ready) |=>
            (wr_state == decompose_pkg::DCMP_WR_IDLE)
    ) else $error("write FSM started without r0_ready");

    done_low_when_busy_a: assert property (
        @(posedge clk) disable iff (!reset_n)
        (rd_busy || wr_state == decompose_pkg::DCMP_WR_MEM) |-> !decompose_done
    ) else $error("decompose_done high during a run");

endmodule

// ==== rtl/mod_2gamma2_unit.sv ====
`timescale 1ns/1ps
`include "decompose_config.svh"

module mod_2gamma2_unit (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize,
    input  decompose_pkg::mem_op_e   rd_op,
    input  decompose_pkg::src_word_t rd_data,
    dcmp_result_if.r0_src            result
);

    localparam decompose_pkg::r0_t GAMMA2     = decompose_pkg::r0_t'(`DCMP_GAMMA2);
    localparam decompose_pkg::r0_t TWO_GAMMA2 = decompose_pkg::r0_t'(2 * `DCMP_GAMMA2);

    // High in the cycle the memory presents read data
    logic rd_data_vld;

    decompose_pkg::coeff_t coeff   [`DCMP_LANES];
    decompose_pkg::coeff_t rem     [`DCMP_LANES];
    decompose_pkg::r0_t    rem_s   [`DCMP_LANES];
    decompose_pkg::r0_t    r0_next [`DCMP_LANES];

    // -----------------------------------------------------------------
    // Centered reduction, r0 in (-gamma2, gamma2]
    // -----------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < `DCMP_LANES; i++) begin
            coeff[i] = rd_data[i*`DCMP_COEFF_W +: `DCMP_COEFF_W];
            rem[i]   = coeff[i] % decompose_pkg::coeff_t'(2 * `DCMP_GAMMA2);
            // Remainder is below 2^19 so it stays positive in r0_t
            rem_s[i] = decompose_pkg::r0_t'(rem[i]);
            if (rem_s[i] > GAMMA2) begin
                r0_next[i] = rem_s[i] - TWO_GAMMA2;
            end else begin
                r0_next[i] = rem_s[i];
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_data_vld     <= 1'b0;
            result.r0_valid <= 1'b0;
        end else if (zeroize) begin
            rd_data_vld     <= 1'b0;
            result.r0_valid <= 1'b0;
        end else begin
            rd_data_vld     <= (rd_op == decompose_pkg::RW_READ);
            result.r0_valid <= rd_data_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_data_vld) begin
            for (int i = 0; i < `DCMP_LANES; i++) begin
                result.r0[i] <= r0_next[i];
            end
        end
    end

    for (genvar g = 0; g < `DCMP_LANES; g++) begin : g_range_chk
        r0_range_a: assert property (
            @(posedge clk) disable iff (!reset_n)
            result.r0_valid |-> (result.r0[g] > -GAMMA2) && (result.r0[g] <= GAMMA2)
        ) else $error("r0 lane %0d out of range", g);
    end

endmodule

// ==== rtl/high_bits_unit.sv ====
`timescale 1ns/1ps
`include "decompose_config.svh"

module high_bits_unit (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize,
    input  decompose_pkg::mem_op_e   rd_op,
    input  decompose_pkg::src_word_t rd_data,
    dcmp_result_if.r1_src            result
);

    logic rd_data_vld;

    decompose_pkg::coeff_t  coeff   [`DCMP_LANES];
    decompose_pkg::r1_raw_t r1_next [`DCMP_LANES];

    // -----------------------------------------------------------------
    // Threshold ladder
    // -----------------------------------------------------------------
    // r1 is the number of odd multiples of gamma2 strictly below r
    always_comb begin
        for (int i = 0; i < `DCMP_LANES; i++) begin
            coeff[i]   = rd_data[i*`DCMP_COEFF_W +: `DCMP_COEFF_W];
            r1_next[i] = '0;
            for (int k = 0; k < 16; k++) begin
                if (coeff[i] > decompose_pkg::coeff_t'((2*k + 1) * `DCMP_GAMMA2)) begin
                    r1_next[i] = r1_next[i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_data_vld     <= 1'b0;
            result.r1_valid <= 1'b0;
        end else if (zeroize) begin
            rd_data_vld     <= 1'b0;
            result.r1_valid <= 1'b0;
        end else begin
            rd_data_vld     <= (rd_op == decompose_pkg::RW_READ);
            result.r1_valid <= rd_data_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_data_vld) begin
            for (int i = 0; i < `DCMP_LANES; i++) begin
                result.r1[i] <= r1_next[i];
            end
        end
    end

    // Both arithmetic paths must stay in lockstep
    path_align_a: assert property (
        @(posedge clk) disable iff (!reset_n)
        result.r1_valid == result.r0_valid
    ) else $error("r0 and r1 paths out of step");

endmodule

// ==== rtl/decompose_combine.sv ====
`timescale 1ns/1ps
`include "decompose_config.svh"

module decompose_combine (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize,
    dcmp_result_if.sink                 parts,
    output decompose_pkg::result_word_t wr_data,
    output logic                        data_valid
);

    localparam int LANE_W = $bits(decompose_pkg::r1_t) + `DCMP_COEFF_W;

    decompose_pkg::r1_t    r1_fix  [`DCMP_LANES];
    decompose_pkg::r0_t    r0_adj  [`DCMP_LANES];
    decompose_pkg::coeff_t r0_modq [`DCMP_LANES];
    decompose_pkg::result_word_t packed_nxt;

    // -----------------------------------------------------------------
    // q-1 corner case and mod-q form of r0
    // -----------------------------------------------------------------
    always_comb begin
        packed_nxt = '0;
        for (int i = 0; i < `DCMP_LANES; i++) begin
            // Raw r1 of 16 means r - r0 = q-1
            if (parts.r1[i] == 5'd16) begin
                r1_fix[i] = '0;
                r0_adj[i] = parts.r0[i] - decompose_pkg::r0_t'(1);
            end else begin
                r1_fix[i] = parts.r1[i][3:0];
                r0_adj[i] = parts.r0[i];
            end
            if (r0_adj[i] < 0) begin
                r0_modq[i] = decompose_pkg::coeff_t'(int'(r0_adj[i]) + `DCMP_Q);
            end else begin
                r0_modq[i] = decompose_pkg::coeff_t'(r0_adj[i]);
            end
            packed_nxt[i*LANE_W +: LANE_W] = {r1_fix[i], r0_modq[i]};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_valid <= 1'b0;
        end else if (zeroize) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= parts.r0_valid && parts.r1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (parts.r0_valid && parts.r1_valid) begin
            wr_data <= packed_nxt;
        end
    end

    for (genvar g = 0; g < `DCMP_LANES; g++) begin : g_result_chk
        r0_below_q_a: assert property (
            @(posedge clk) disable iff (!reset_n)
            data_valid |-> (wr_data[g*LANE_W +: `DCMP_COEFF_W] < `DCMP_Q)
        ) else $error("result lane %0d has r0 outside [0, q)", g);
    end

endmodule

// ==== rtl/decompose_top.sv ====
`timescale 1ns/1ps

module decompose_top (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize,
    input  logic                        host_wr_en,
    input  decompose_pkg::mem_addr_t    host_addr,
    input  decompose_pkg::src_word_t    host_wdata,
    input  logic                        decompose_enable,
    input  decompose_pkg::mem_addr_t    src_base_addr,
    input  decompose_pkg::mem_addr_t    dest_base_addr,
    output logic                        wr_en,
    output decompose_pkg::mem_addr_t    wr_addr,
    output decompose_pkg::result_word_t wr_data,
    output logic                        decompose_done
);

    decompose_pkg::mem_op_e   rd_op;
    decompose_pkg::mem_op_e   wr_op;
    decompose_pkg::mem_addr_t rd_addr;
    decompose_pkg::src_word_t rd_data;

    dcmp_result_if result_if ();

    poly_src_mem i_src_mem (
        .clk        (clk),
        .host_wr_en (host_wr_en),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .rd_op      (rd_op),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    decompose_ctrl i_ctrl (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize          (zeroize),
        .decompose_enable (decompose_enable),
        .src_base_addr    (src_base_addr),
        .dest_base_addr   (dest_base_addr),
        .r0_ready         (result_if.r0_valid),
        .rd_op            (rd_op),
        .rd_addr          (rd_addr),
        .wr_op            (wr_op),
        .wr_addr          (wr_addr),
        .decompose_done   (decompose_done)
    );

    mod_2gamma2_unit i_mod_2gamma2 (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .rd_op   (rd_op),
        .rd_data (rd_data),
        .result  (result_if.r0_src)
    );

    high_bits_unit i_high_bits (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .rd_op   (rd_op),
        .rd_data (rd_data),
        .result  (result_if.r1_src)
    );

    // Result valid is checked inside the combiner
    decompose_combine i_combine (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .parts      (result_if.sink),
        .wr_data    (wr_data),
        .data_valid ()
    );

    assign wr_en = (wr_op == decompose_pkg::RW_WRITE);

endmodule

// ==== tests/tb_decompose.sv ====
`timescale 1ns/1ps
`include "decompose_config.svh"

module tb_decompose;

    localparam int DEPTH        = 1 << `DCMP_ADDR_W;
    localparam int WORDS        = `DCMP_K * `DCMP_N / `DCMP_LANES;
    localparam int LANE_W       = 4 + `DCMP_COEFF_W;
    // Start strobe to done: 512 reads plus the 3-stage pipeline plus the return to idle
    localparam int RUN_CYCLES   = WORDS + 4;
    localparam int RESET_CYCLES = 5;
    // 1024 load cycles and 3 runs of 516 come to about 2600, nearly doubled
    localparam int CYCLE_LIMIT  = 5000;

    logic                        clk;
    logic                        reset_n;
    logic                        zeroize;
    logic                        host_wr_en;
    decompose_pkg::mem_addr_t    host_addr;
    decompose_pkg::src_word_t    host_wdata;
    logic                        decompose_enable;
    decompose_pkg::mem_addr_t    src_base_addr;
    decompose_pkg::mem_addr_t    dest_base_addr;
    logic                        wr_en;
    decompose_pkg::mem_addr_t    wr_addr;
    decompose_pkg::result_word_t wr_data;
    logic                        decompose_done;

    decompose_pkg::src_word_t model_mem [DEPTH];
    decompose_pkg::mem_addr_t run_src;
    decompose_pkg::mem_addr_t run_dest;
    int                       write_idx;
    logic                     writes_allowed;
    int                       cycle_count;
    string                    test_name;

    decompose_top i_dut (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize          (zeroize),
        .host_wr_en       (host_wr_en),
        .host_addr        (host_addr),
        .host_wdata       (host_wdata),
        .decompose_enable (decompose_enable),
        .src_base_addr    (src_base_addr),
        .dest_base_addr   (dest_base_addr),
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .decompose_done   (decompose_done)
    );

    always #2 clk = ~clk;

    // ---------------------------------------------------------------------
    // Failure reporting
    // ---------------------------------------------------------------------
    task automatic stop_on_failure();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic report_mismatch(input string what, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        stop_on_failure();
    endtask

    task automatic report_failure(input string what);
        $display("Error in %s: %s", test_name, what);
        stop_on_failure();
    endtask

    // ---------------------------------------------------------------------
    // Stimulus and reference model
    // ---------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic decompose_pkg::src_word_t pack_coeffs(input int c0, input int c1,
                                                             input int c2, input int c3);
        return {decompose_pkg::coeff_t'(c3), decompose_pkg::coeff_t'(c2),
                decompose_pkg::coeff_t'(c1), decompose_pkg::coeff_t'(c0)};
    endfunction

    // Centered split r = r1*2*gamma2 + r0, with q-1 folded back to r1 = 0
    function automatic logic [LANE_W-1:0] model_lane(input int r);
        int two_g;
        int r0;
        int r1;
        two_g = 2 * `DCMP_GAMMA2;
        r0 = r % two_g;
        if (r0 > `DCMP_GAMMA2) begin
            r0 = r0 - two_g;
        end
        if (r - r0 == `DCMP_Q - 1) begin
            r1 = 0;
            r0 = r0 - 1;
        end else begin
            r1 = (r - r0) / two_g;
        end
        if (r0 < 0) begin
            r0 = r0 + `DCMP_Q;
        end
        return {r1[3:0], r0[`DCMP_COEFF_W-1:0]};
    endfunction

    function automatic decompose_pkg::result_word_t model_word(
        input decompose_pkg::src_word_t w
    );
        decompose_pkg::result_word_t res;
        res = '0;
        for (int l = 0; l < `DCMP_LANES; l++) begin
            res[l*LANE_W +: LANE_W] = model_lane(int'(w[l*`DCMP_COEFF_W +: `DCMP_COEFF_W]));
        end
        return res;
    endfunction

    task automatic fill_model();
        logic [31:0] state;
        state = 32'd53633;
        for (int a = 0; a < DEPTH; a++) begin
            for (int l = 0; l < `DCMP_LANES; l++) begin
                state = xorshift32(state);
                model_mem[a][l*`DCMP_COEFF_W +: `DCMP_COEFF_W] =
                    decompose_pkg::coeff_t'(state % `DCMP_Q);
            end
        end
        // Boundary coefficients, placed inside the run windows below
        model_mem[5]    = pack_coeffs(`DCMP_Q - 1, 0, `DCMP_GAMMA2, `DCMP_GAMMA2 + 1);
        model_mem[6]    = pack_coeffs(2 * `DCMP_GAMMA2, 31 * `DCMP_GAMMA2, `DCMP_Q - 2,
                                      31 * `DCMP_GAMMA2 + 1);
        model_mem[150]  = pack_coeffs(`DCMP_Q - 1, `DCMP_Q - 1, 1, `DCMP_GAMMA2 - 1);
        model_mem[1000] = pack_coeffs(`DCMP_GAMMA2 + 1, `DCMP_GAMMA2, 0, `DCMP_Q - 1);
    endtask

    task automatic next_drive_point();
        @(posedge clk);
        #0.5;
    endtask

    task automatic load_memory();
        for (int a = 0; a < DEPTH; a++) begin
            host_wr_en = 1'b1;
            host_addr  = decompose_pkg::mem_addr_t'(a);
            host_wdata = model_mem[a];
            next_drive_point();
        end
        host_wr_en = 1'b0;
    endtask

    // Set the bases and pulse decompose_enable for one cycle
    task automatic start_strobe(input decompose_pkg::mem_addr_t src,
                                input decompose_pkg::mem_addr_t dest);
        run_src          = src;
        run_dest         = dest;
        write_idx        = 0;
        writes_allowed   = 1'b1;
        src_base_addr    = src;
        dest_base_addr   = dest;
        decompose_enable = 1'b1;
        next_drive_point();
        decompose_enable = 1'b0;
    endtask

    task automatic run_block(input string name, input decompose_pkg::mem_addr_t src,
                             input decompose_pkg::mem_addr_t dest);
        int cycles;
        test_name = name;
        start_strobe(src, dest);
        cycles = 1;
        @(negedge clk);
        assert (!decompose_done) else report_failure("decompose_done did not fall after start");
        while (!decompose_done && cycles < RUN_CYCLES + 20) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        assert (decompose_done) else report_failure("decompose_done never rose again");
        assert (cycles == RUN_CYCLES) else report_mismatch("done latency", RUN_CYCLES, cycles);
        assert (write_idx == WORDS) else report_mismatch("write count", WORDS, write_idx);
        next_drive_point();
    endtask

    task automatic abort_run(input decompose_pkg::mem_addr_t src,
                             input decompose_pkg::mem_addr_t dest, input int abort_after);
        int guard;
        test_name = "zeroize_abort";
        start_strobe(src, dest);
        guard = 0;
        while (write_idx < abort_after && guard < RUN_CYCLES) begin
            next_drive_point();
            guard = guard + 1;
        end
        assert (write_idx >= abort_after) else report_failure("writes never started");
        zeroize = 1'b1;
        next_drive_point();
        zeroize        = 1'b0;
        writes_allowed = 1'b0;
        @(negedge clk);
        assert (decompose_done) else report_failure("decompose_done low after zeroize");
        // Stay long enough that any stale write would have shown up
        repeat (RUN_CYCLES) begin
            @(negedge clk);
            assert (decompose_done) else report_failure("decompose_done fell after zeroize");
        end
        next_drive_point();
    endtask

    // ---------------------------------------------------------------------
    // Write port checker, sampled mid-cycle
    // ---------------------------------------------------------------------
    always @(negedge clk) begin : check_writes
        decompose_pkg::mem_addr_t    exp_addr;
        decompose_pkg::result_word_t exp_data;
        if (reset_n) begin
            if (wr_en) begin
                assert (writes_allowed && write_idx < WORDS)
                    else report_failure("write outside a decompose run");
                exp_addr = decompose_pkg::mem_addr_t'(run_dest + write_idx);
                exp_data = model_word(model_mem[decompose_pkg::mem_addr_t'(run_src + write_idx)]);
                assert (wr_addr == exp_addr) else report_mismatch("wr_addr", exp_addr, wr_addr);
                assert (wr_data == exp_data) else report_mismatch("wr_data", exp_data, wr_data);
                write_idx = write_idx + 1;
            end else if (writes_allowed) begin
                assert (write_idx == 0 || write_idx >= WORDS)
                    else report_failure("gap in the write burst");
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            report_failure("run did not finish within the cycle limit");
        end
    end

    // ---------------------------------------------------------------------
    // Test sequence
    // ---------------------------------------------------------------------
    initial begin
        clk              = 1'b0;
        reset_n          = 1'b0;
        zeroize          = 1'b0;
        host_wr_en       = 1'b0;
        host_addr        = '0;
        host_wdata       = '0;
        decompose_enable = 1'b0;
        src_base_addr    = '0;
        dest_base_addr   = '0;
        run_src          = '0;
        run_dest         = '0;
        write_idx        = 0;
        writes_allowed   = 1'b0;
        cycle_count      = 0;
        test_name        = "reset";
        fill_model();

        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        reset_n = 1'b1;
        @(negedge clk);
        assert (decompose_done) else report_mismatch("decompose_done", 1, decompose_done);
        assert (!wr_en) else report_mismatch("wr_en", 0, wr_en);
        next_drive_point();

        test_name = "host_load";
        load_memory();
        next_drive_point();

        run_block("run_base_zero", 10'd0, 10'h200);
        // Both windows cross the top of the memory
        run_block("run_wrapped", 10'd700, 10'd900);
        abort_run(10'd100, 10'd300, 100);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/decompose_pkg.sv
rtl/dcmp_result_if.sv
rtl/poly_src_mem.sv
rtl/decompose_ctrl.sv
rtl/mod_2gamma2_unit.sv
rtl/high_bits_unit.sv
rtl/decompose_combine.sv
rtl/decompose_top.sv
tests/tb_decompose.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the decompose testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_decompose \
    -f vlog.f \
    -o Vtb_decompose

./obj_dir/Vtb_decompose | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
